// ==== Makefile ====
VERILATOR  := verilator
TOP        := coreTb
FLIST      := flist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert --Mdir $(OBJ_DIR)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
+incdir+source
+incdir+testbench
source/isaPkg.sv
source/pipePkg.sv
source/programMemory.sv
source/instructionDecoder.sv
source/registerFile.sv
source/executeUnit.sv
source/pipelineCore.sv
testbench/tbClock.sv
testbench/coreTb.sv

// ==== source/cpu_defines.svh ====
// ==========================================================================
// Core width and size macros
// ==========================================================================

`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data and instruction word
`define CPU_WORD_W 16

// Register file
`define CPU_REG_COUNT 8
`define CPU_REG_SEL_W 3

// Instruction memory, in 16-bit words
`define CPU_IMEM_DEPTH 256
`define CPU_IMEM_ADDR_W 8

`endif

// ==== source/executeUnit.sv ====
// ==========================================================================
// Execute stage: forwarding, ALU, branch resolve
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module executeUnit (
	input  wire [`CPU_WORD_W-1:0]     pc,
	input  wire [`CPU_WORD_W-1:0]     operandA,
	input  wire [`CPU_WORD_W-1:0]     operandB,
	input  wire [`CPU_REG_SEL_W-1:0]  srcA,
	input  wire [`CPU_REG_SEL_W-1:0]  srcB,
	input  wire isaPkg::aluOpT        aluOp,
	input  wire                       useImm,
	input  wire [`CPU_WORD_W-1:0]     imm,
	input  wire                       isBranch,
	input  wire                       branchOnZero,
	input  wire                       isJump,
	input  wire [`CPU_WORD_W-1:0]     wbResult,
	input  wire [`CPU_REG_SEL_W-1:0]  wbDest,
	input  wire                       wbWrite,
	output logic [`CPU_WORD_W-1:0]    result,
	output logic                      redirect,
	output logic [`CPU_WORD_W-1:0]    target
);

	import isaPkg::*;
	import pipePkg::*;

	fwdSelT selA;
	fwdSelT selB;
	logic [`CPU_WORD_W-1:0] opA;
	logic [`CPU_WORD_W-1:0] opB;
	logic [`CPU_WORD_W-1:0] aluB;
	logic isZero;

	// EX/WB result wins over the latched register value
	assign selA = (wbWrite && wbDest == srcA) ? fwdWb : fwdReg;
	assign selB = (wbWrite && wbDest == srcB) ? fwdWb : fwdReg;

	assign opA  = (selA == fwdWb) ? wbResult : operandA;
	assign opB  = (selB == fwdWb) ? wbResult : operandB;
	assign aluB = useImm ? imm : opB;

	always_comb begin
		case (aluOp)
			aluAdd:  result = opA + aluB;
			// Reverse subtract: second operand minus Rs
			aluSub:  result = aluB - opA;
			aluXor:  result = opA ^ aluB;
			aluAndn: result = opA & ~aluB;
			default: result = aluB;
		endcase
	end

	assign isZero = (opA == '0);

	// Displacement is relative to the next sequential PC
	assign target   = pc + `CPU_WORD_W'(2) + imm;
	assign redirect = isJump | (isBranch & (branchOnZero ? isZero : ~isZero));

endmodule

`default_nettype wire

// ==== source/instructionDecoder.sv ====
// ==========================================================================
// Instruction decoder
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module instructionDecoder (
	input  wire [`CPU_WORD_W-1:0]     instr,
	output isaPkg::aluOpT             aluOp,
	output logic [`CPU_REG_SEL_W-1:0] srcA,
	output logic [`CPU_REG_SEL_W-1:0] srcB,
	output logic [`CPU_REG_SEL_W-1:0] dest,
	output logic                      readA,
	output logic                      readB,
	output logic                      regWrite,
	output logic                      useImm,
	output logic [`CPU_WORD_W-1:0]    imm,
	output logic                      isBranch,
	output logic                      branchOnZero,
	output logic                      isJump,
	output logic                      isHalt,
	output logic                      illegal
);

	import isaPkg::*;

	opcodeT opcode;
	funcT   func;
	logic [`CPU_WORD_W-1:0] immSext5;
	logic [`CPU_WORD_W-1:0] immZext5;
	logic [`CPU_WORD_W-1:0] immSext8;
	logic [`CPU_WORD_W-1:0] immSext11;

	assign opcode = opcodeT'(instr[15:11]);
	assign func   = funcT'(instr[1:0]);

	// Rs and Rt sit at fixed positions in every format
	assign srcA = instr[10:8];
	assign srcB = instr[7:5];

	assign immSext5  = {{(`CPU_WORD_W-5){instr[4]}}, instr[4:0]};
	assign immZext5  = {{(`CPU_WORD_W-5){1'b0}}, instr[4:0]};
	assign immSext8  = {{(`CPU_WORD_W-8){instr[7]}}, instr[7:0]};
	assign immSext11 = {{(`CPU_WORD_W-11){instr[10]}}, instr[10:0]};

	always_comb begin
		aluOp        = aluAdd;
		dest         = instr[7:5];
		readA        = 1'b0;
		readB        = 1'b0;
		regWrite     = 1'b0;
		useImm       = 1'b0;
		imm          = immSext5;
		isBranch     = 1'b0;
		branchOnZero = 1'b0;
		isJump       = 1'b0;
		isHalt       = 1'b0;
		illegal      = 1'b0;
		case (opcode)
			opHalt: isHalt = 1'b1;
			opNop: begin
			end
			opAddi, opSubi, opXori, opAndni: begin
				readA    = 1'b1;
				regWrite = 1'b1;
				useImm   = 1'b1;
				case (opcode)
					opSubi:  aluOp = aluSub;
					opXori:  aluOp = aluXor;
					opAndni: aluOp = aluAndn;
					default: aluOp = aluAdd;
				endcase
				// Logical immediates are zero extended
				if (opcode == opXori || opcode == opAndni) begin
					imm = immZext5;
				end
			end
			opLbi: begin
				aluOp    = aluPassB;
				dest     = instr[10:8];
				regWrite = 1'b1;
				useImm   = 1'b1;
				imm      = immSext8;
			end
			opAluReg: begin
				dest     = instr[4:2];
				readA    = 1'b1;
				readB    = 1'b1;
				regWrite = 1'b1;
				case (func)
					funcSub:  aluOp = aluSub;
					funcXor:  aluOp = aluXor;
					funcAndn: aluOp = aluAndn;
					default:  aluOp = aluAdd;
				endcase
			end
			opBeqz, opBnez: begin
				readA        = 1'b1;
				isBranch     = 1'b1;
				branchOnZero = (opcode == opBeqz);
				imm          = immSext8;
			end
			opJ: begin
				isJump = 1'b1;
				imm    = immSext11;
			end
			default: illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/isaPkg.sv ====
// ==========================================================================
// Instruction set types
// ==========================================================================

`default_nettype none

package isaPkg;

	// Major opcode, instruction bits [15:11]
	typedef enum logic [4:0] {
		opHalt   = 5'b00000,
		opNop    = 5'b00001,
		opJ      = 5'b00100,
		opAddi   = 5'b01000,
		opSubi   = 5'b01001,
		opXori   = 5'b01010,
		opAndni  = 5'b01011,
		opBeqz   = 5'b01100,
		opBnez   = 5'b01101,
		opLbi    = 5'b11000,
		opAluReg = 5'b11011
	} opcodeT;

	typedef enum logic [2:0] {
		aluAdd   = 3'd0,
		aluSub   = 3'd1,
		aluXor   = 3'd2,
		aluAndn  = 3'd3,
		aluPassB = 3'd4
	} aluOpT;

	// Register group function, bits [1:0]
	typedef enum logic [1:0] {
		funcAdd  = 2'b00,
		funcSub  = 2'b01,
		funcXor  = 2'b10,
		funcAndn = 2'b11
	} funcT;

endpackage

`default_nettype wire

// ==== source/pipePkg.sv ====
// ==========================================================================
// Pipeline control types
// ==========================================================================

`default_nettype none

package pipePkg;

	typedef enum logic [1:0] {
		stIdle   = 2'd0,
		stRun    = 2'd1,
		stHalted = 2'd2
	} coreStateT;

	// Operand source for EX
	typedef enum logic {
		fwdReg = 1'b0,
		fwdWb  = 1'b1
	} fwdSelT;

endpackage

`default_nettype wire

// ==== source/pipelineCore.sv ====
// ==========================================================================
// Four-stage pipelined core
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module pipelineCore (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        start,
	input  wire                        loadReq,
	input  wire [`CPU_IMEM_ADDR_W-1:0] loadAddr,
	input  wire [`CPU_WORD_W-1:0]      loadData,
	output logic                       loadAck,
	output logic                       wbValid,
	output logic [`CPU_REG_SEL_W-1:0]  wbReg,
	output logic [`CPU_WORD_W-1:0]     wbData,
	output logic                       halted,
	output logic                       err
);

	import isaPkg::*;
	import pipePkg::*;

	coreStateT state;
	logic [`CPU_WORD_W-1:0] pc;
	logic [`CPU_WORD_W-1:0] fetchWord;
	logic running;
	logic takeRedirect;
	logic stopPipe;
	logic flush;

	// IF/ID
	logic ifIdValid;
	logic [`CPU_WORD_W-1:0] ifIdInstr;
	logic [`CPU_WORD_W-1:0] ifIdPc;

	// Decode outputs
	aluOpT decAluOp;
	logic [`CPU_REG_SEL_W-1:0] decSrcA, decSrcB, decDest;
	logic decReadA, decReadB, decRegWrite, decUseImm;
	logic [`CPU_WORD_W-1:0] decImm;
	logic decIsBranch, decBranchOnZero, decIsJump, decIsHalt, decIllegal;
	logic [`CPU_WORD_W-1:0] rfDataA, rfDataB;

	// ID/EX
	logic idExValid;
	aluOpT idExAluOp;
	logic [`CPU_WORD_W-1:0] idExPc, idExOpA, idExOpB, idExImm;
	logic [`CPU_REG_SEL_W-1:0] idExSrcA, idExSrcB, idExDest;
	logic idExRegWrite, idExUseImm, idExIsBranch, idExBranchOnZero;
	logic idExIsJump, idExIsHalt, idExIllegal;

	// EX/WB
	logic [`CPU_WORD_W-1:0] exResult, exTarget;
	logic exRedirect;
	logic exWbValid, exWbRegWrite;
	logic [`CPU_REG_SEL_W-1:0] exWbDest;
	logic [`CPU_WORD_W-1:0] exWbResult;

	assign running      = (state == stRun);
	assign takeRedirect = idExValid & exRedirect;
	assign stopPipe     = idExValid & (idExIsHalt | idExIllegal);
	// Both younger slots are dropped on either event
	assign flush        = takeRedirect | stopPipe;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
			pc    <= '0;
			err   <= 1'b0;
		end else begin
			case (state)
				stIdle: begin
					pc <= '0;
					if (start) begin
						state <= stRun;
					end
				end
				stRun: begin
					if (takeRedirect) begin
						pc <= exTarget;
					end else if (stopPipe) begin
						state <= stHalted;
						err   <= idExIllegal;
					end else begin
						pc <= pc + `CPU_WORD_W'(2);
					end
				end
				default: state <= stHalted;
			endcase
		end
	end

	assign halted = (state == stHalted);

	programMemory imem0 (
		.clk(clk), .rst(rst), .idle(state == stIdle),
		.loadReq(loadReq), .loadAddr(loadAddr), .loadData(loadData),
		.fetchAddr(pc[`CPU_IMEM_ADDR_W:1]), .loadAck(loadAck), .fetchWord(fetchWord)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			ifIdValid <= 1'b0;
			idExValid <= 1'b0;
			exWbValid <= 1'b0;
		end else begin
			ifIdValid <= running & ~flush;
			idExValid <= ifIdValid & ~flush;
			exWbValid <= idExValid;
		end
	end

	always_ff @(posedge clk) begin
		ifIdInstr <= fetchWord;
		ifIdPc    <= pc;
	end

	instructionDecoder dec0 (
		.instr(ifIdInstr), .aluOp(decAluOp), .srcA(decSrcA), .srcB(decSrcB),
		.dest(decDest), .readA(decReadA), .readB(decReadB), .regWrite(decRegWrite),
		.useImm(decUseImm), .imm(decImm), .isBranch(decIsBranch),
		.branchOnZero(decBranchOnZero), .isJump(decIsJump), .isHalt(decIsHalt),
		.illegal(decIllegal)
	);

	registerFile rf0 (
		.clk(clk), .rst(rst), .readSelA(decSrcA), .readSelB(decSrcB),
		.writeSel(exWbDest), .writeData(exWbResult), .writeEn(wbValid),
		.readDataA(rfDataA), .readDataB(rfDataB)
	);

	always_ff @(posedge clk) begin
		idExPc           <= ifIdPc;
		// Unused operands are held at zero
		idExOpA          <= decReadA ? rfDataA : '0;
		idExOpB          <= decReadB ? rfDataB : '0;
		idExSrcA         <= decSrcA;
		idExSrcB         <= decSrcB;
		idExAluOp        <= decAluOp;
		idExDest         <= decDest;
		idExRegWrite     <= decRegWrite;
		idExUseImm       <= decUseImm;
		idExImm          <= decImm;
		idExIsBranch     <= decIsBranch;
		idExBranchOnZero <= decBranchOnZero;
		idExIsJump       <= decIsJump;
		idExIsHalt       <= decIsHalt;
		idExIllegal      <= decIllegal;
	end

	executeUnit ex0 (
		.pc(idExPc), .operandA(idExOpA), .operandB(idExOpB),
		.srcA(idExSrcA), .srcB(idExSrcB), .aluOp(idExAluOp), .useImm(idExUseImm),
		.imm(idExImm), .isBranch(idExIsBranch), .branchOnZero(idExBranchOnZero),
		.isJump(idExIsJump), .wbResult(exWbResult), .wbDest(exWbDest), .wbWrite(wbValid),
		.result(exResult), .redirect(exRedirect), .target(exTarget)
	);

	always_ff @(posedge clk) begin
		exWbRegWrite <= idExRegWrite;
		exWbDest     <= idExDest;
		exWbResult   <= exResult;
	end

	// Retired write, also the forwarding source
	assign wbValid = exWbValid & exWbRegWrite;
	assign wbReg   = exWbDest;
	assign wbData  = exWbResult;

endmodule

`default_nettype wire

// ==== source/programMemory.sv ====
// ==========================================================================
// Instruction RAM with load port
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module programMemory (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          idle,
	input  wire                          loadReq,
	input  wire [`CPU_IMEM_ADDR_W-1:0]   loadAddr,
	input  wire [`CPU_WORD_W-1:0]        loadData,
	input  wire [`CPU_IMEM_ADDR_W-1:0]   fetchAddr,
	output logic                         loadAck,
	output logic [`CPU_WORD_W-1:0]       fetchWord
);

	logic [`CPU_WORD_W-1:0] mem [`CPU_IMEM_DEPTH];
	logic loadTake;

	// New request seen while idle and not yet acknowledged
	assign loadTake = loadReq & idle & ~loadAck;

	// Ack follows req, but only rises while idle
	always_ff @(posedge clk) begin
		if (rst) begin
			loadAck <= 1'b0;
		end else begin
			loadAck <= loadReq & (idle | loadAck);
		end
	end

	always_ff @(posedge clk) begin
		if (loadTake) begin
			mem[loadAddr] <= loadData;
		end
	end

	// Fetch is asynchronous
	assign fetchWord = mem[fetchAddr];

endmodule

`default_nettype wire

// ==== source/registerFile.sv ====
// ==========================================================================
// Register file with write bypass
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module registerFile (
	input  wire                       clk,
	input  wire                       rst,
	input  wire [`CPU_REG_SEL_W-1:0]  readSelA,
	input  wire [`CPU_REG_SEL_W-1:0]  readSelB,
	input  wire [`CPU_REG_SEL_W-1:0]  writeSel,
	input  wire [`CPU_WORD_W-1:0]     writeData,
	input  wire                       writeEn,
	output logic [`CPU_WORD_W-1:0]    readDataA,
	output logic [`CPU_WORD_W-1:0]    readDataB
);

	logic [`CPU_WORD_W-1:0] regs [`CPU_REG_COUNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeSel] <= writeData;
		end
	end

	// Same-cycle write is visible to the reader
	assign readDataA = (writeEn && writeSel == readSelA) ? writeData : regs[readSelA];
	assign readDataB = (writeEn && writeSel == readSelB) ? writeData : regs[readSelB];

endmodule

`default_nettype wire

// ==== testbench/tbModel.svh ====
// ==========================================================================
// Reference model and random source
// ==========================================================================

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Maximal length 8-bit Fibonacci register, taps 8 6 5 4
function automatic logic [7:0] lfsrStep(input logic [7:0] s);
	return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
endfunction

// One register step for every bit taken
function automatic logic [15:0] takeBits(input int n);
	logic [15:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsrState = lfsrStep(lfsrState);
		v = {v[14:0], lfsrState[0]};
	end
	return v;
endfunction

// Runs prog from address zero and queues every register write it makes
function automatic void runModel();
	logic [`CPU_WORD_W-1:0] regs [`CPU_REG_COUNT];
	logic [`CPU_WORD_W-1:0] instr;
	logic [`CPU_WORD_W-1:0] a;
	logic [`CPU_WORD_W-1:0] b;
	logic [`CPU_WORD_W-1:0] res;
	logic [`CPU_WORD_W-1:0] pc;
	logic [`CPU_WORD_W-1:0] imm5;
	logic [`CPU_WORD_W-1:0] uimm5;
	logic [`CPU_WORD_W-1:0] imm8;
	logic [`CPU_REG_SEL_W-1:0] rd;
	logic wr;
	logic done;
	int steps;
	regs = '{default: '0};
	expRegQ.delete();
	expDataQ.delete();
	expectErr = 1'b0;
	pc = '0;
	done = 1'b0;
	steps = 0;
	while (!done && steps < 1000) begin
		instr = prog[pc[`CPU_IMEM_ADDR_W:1]];
		a = regs[instr[10:8]];
		b = regs[instr[7:5]];
		imm5 = {{11{instr[4]}}, instr[4:0]};
		uimm5 = {11'd0, instr[4:0]};
		imm8 = {{8{instr[7]}}, instr[7:0]};
		rd = instr[7:5];
		res = '0;
		wr = instr[15:11] inside {opAddi, opSubi, opXori, opAndni, opLbi, opAluReg};
		// Sequential next PC, displacements add to it
		pc = pc + 16'd2;
		steps++;
		case (instr[15:11])
			opAddi:  res = a + imm5;
			opSubi:  res = imm5 - a;
			opXori:  res = a ^ uimm5;
			opAndni: res = a & ~uimm5;
			opLbi: begin
				rd  = instr[10:8];
				res = imm8;
			end
			opAluReg: begin
				rd = instr[4:2];
				case (instr[1:0])
					2'd0:    res = a + b;
					2'd1:    res = b - a;
					2'd2:    res = a ^ b;
					default: res = a & ~b;
				endcase
			end
			opBeqz: begin
				if (a == '0) begin
					pc = pc + imm8;
				end
			end
			opBnez: begin
				if (a != '0) begin
					pc = pc + imm8;
				end
			end
			opJ:    pc = pc + {{5{instr[10]}}, instr[10:0]};
			opHalt: done = 1'b1;
			opNop: begin
			end
			default: begin
				expectErr = 1'b1;
				done = 1'b1;
			end
		endcase
		if (wr) begin
			regs[rd] = res;
			expRegQ.push_back(rd);
			expDataQ.push_back(res);
		end
	end
endfunction

`endif

// ==== testbench/coreTb.sv ====
// ==========================================================================
// Pipelined core testbench
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module coreTb;

	import isaPkg::*;

	localparam int clkPeriod   = 8;
	localparam int resetCycles = 10;
	localparam int arithLen    = 48;
	localparam int blockCount  = 8;
	localparam int illegalAt   = 12;
	// Words of all three programs with two padding nops each
	localparam int totalWords  = (arithLen + 6) + (blockCount * 8 + 3) + (illegalAt + 8);
	localparam int loadCycles  = 4 * totalWords + 3 * (resetCycles + 8);
	localparam int watchCycles = 10 * (totalWords + loadCycles);

	logic clk;
	logic rst;
	logic start;
	logic loadReq;
	logic [`CPU_IMEM_ADDR_W-1:0] loadAddr;
	logic [`CPU_WORD_W-1:0] loadData;
	logic loadAck;
	logic wbValid;
	logic [`CPU_REG_SEL_W-1:0] wbReg;
	logic [`CPU_WORD_W-1:0] wbData;
	logic halted;
	logic err;

	logic [`CPU_WORD_W-1:0] prog [`CPU_IMEM_DEPTH];
	int progLen;
	logic [`CPU_REG_SEL_W-1:0] expRegQ [$];
	logic [`CPU_WORD_W-1:0] expDataQ [$];
	logic expectErr;
	logic coreStarted;
	logic [7:0] lfsrState;
	logic [`CPU_REG_SEL_W-1:0] lastDest;
	int errors;
	int wbChecks;

	`include "tbModel.svh"

	tbClock #(.period(clkPeriod)) clkGen (.clk(clk));

	pipelineCore dut0 (
		.clk(clk), .rst(rst), .start(start), .loadReq(loadReq),
		.loadAddr(loadAddr), .loadData(loadData), .loadAck(loadAck),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.halted(halted), .err(err)
	);

	// Handshake protocol
	ackAfterReq: assert property (@(posedge clk) disable iff (rst)
		$rose(loadAck) |-> $past(loadReq)) else begin
		errors++;
		$display("loadAck rose without a pending loadReq");
	end
	ackDropAfterReq: assert property (@(posedge clk) disable iff (rst)
		$fell(loadAck) |-> !$past(loadReq)) else begin
		errors++;
		$display("loadAck fell while loadReq was still high");
	end
	noAckWhenBusy: assert property (@(posedge clk) disable iff (rst)
		coreStarted |-> !$rose(loadAck)) else begin
		errors++;
		$display("loadAck rose after the core left idle");
	end

	// Halt drain and error flag
	quietAfterHalt: assert property (@(posedge clk) disable iff (rst)
		halted |-> !wbValid) else begin
		errors++;
		$display("write-back to r%0d seen after halted", $sampled(wbReg));
	end
	// Error flag rises with halted and holds for the whole halted period
	errAtHalt: assert property (@(posedge clk) disable iff (rst)
		halted |-> err == expectErr) else begin
		errors++;
		$display("[FAIL] err: got %h, expected %h", $sampled(err), $sampled(expectErr));
	end
	errOnlyHalted: assert property (@(posedge clk) disable iff (rst)
		err |-> halted) else begin
		errors++;
		$display("err is high while the core is not halted");
	end

	// Retired writes against the model in order
	always @(negedge clk) begin
		if (!rst && wbValid) begin
			if (expRegQ.size() == 0) begin
				errors++;
				$display("write-back to r%0d beyond the expected sequence", wbReg);
			end else begin
				wbChecks++;
				assert (wbReg == expRegQ[0]) else begin
					errors++;
					$display("[FAIL] wbReg: got %h, expected %h", wbReg, expRegQ[0]);
				end
				assert (wbData == expDataQ[0]) else begin
					errors++;
					$display("[FAIL] wbData: got %h, expected %h", wbData, expDataQ[0]);
				end
				void'(expRegQ.pop_front());
				void'(expDataQ.pop_front());
			end
		end
	end

	// ALU or lbi word whose Rs repeats the last destination half the time
	function automatic logic [15:0] randomAluWord();
		logic [2:0] kind;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] rd;
		logic [15:0] w;
		kind = 3'(takeBits(3));
		rs = (takeBits(1) != '0) ? lastDest : 3'(takeBits(3));
		rt = 3'(takeBits(3));
		rd = 3'(takeBits(3));
		case (kind)
			3'd0:    w = {opAddi, rs, rd, 5'(takeBits(5))};
			3'd1:    w = {opSubi, rs, rd, 5'(takeBits(5))};
			3'd2:    w = {opXori, rs, rd, 5'(takeBits(5))};
			3'd3:    w = {opAndni, rs, rd, 5'(takeBits(5))};
			3'd4:    w = {opLbi, rd, 8'(takeBits(8))};
			default: w = {opAluReg, rs, rt, rd, 2'(takeBits(2))};
		endcase
		lastDest = rd;
		return w;
	endfunction

	task automatic emit(input logic [15:0] w);
		prog[progLen[7:0]] = w;
		progLen++;
	endtask

	task automatic buildArith();
		progLen = 0;
		repeat (arithLen) emit(randomAluWord());
		emit({opHalt, 11'd0});
		// Fetched behind the halt and dropped
		repeat (3) emit(randomAluWord());
	endtask

	// Each block holds lbi and a branch followed by three ALU words and a j over two more
	task automatic buildBranch();
		logic [2:0] rx;
		logic [7:0] value;
		progLen = 0;
		repeat (blockCount) begin
			rx = 3'(takeBits(3));
			value = (takeBits(1) != '0) ? 8'd0 : 8'(takeBits(8));
			emit({opLbi, rx, value});
			emit({(takeBits(1) != '0) ? opBeqz : opBnez, rx, 8'(takeBits(2) * 2)});
			repeat (3) emit(randomAluWord());
			emit({opJ, 11'd4});
			repeat (2) emit(randomAluWord());
		end
		emit({opHalt, 11'd0});
	endtask

	task automatic buildIllegal();
		progLen = 0;
		repeat (illegalAt) emit(randomAluWord());
		// Opcode 11111 is outside the instruction set
		emit({5'b11111, 11'(takeBits(11))});
		repeat (4) emit(randomAluWord());
		emit({opHalt, 11'd0});
	endtask

	task automatic applyReset();
		rst = 1'b1;
		coreStarted = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	task automatic waitAck(input logic level);
		do begin
			@(posedge clk);
			#1;
		end while (loadAck != level);
	endtask

	task automatic loadWord(input logic [7:0] addr, input logic [15:0] data);
		loadAddr = addr;
		loadData = data;
		loadReq = 1'b1;
		waitAck(1'b1);
		loadReq = 1'b0;
		waitAck(1'b0);
	endtask

	task automatic runProgram(input string name);
		applyReset();
		runModel();
		emit({opNop, 11'd0});
		emit({opNop, 11'd0});
		$display("Running %s program, %0d words, %0d writes expected",
			name, progLen, expRegQ.size());
		for (int i = 0; i < progLen; i++) begin
			loadWord(8'(i), prog[8'(i)]);
		end
		start = 1'b1;
		coreStarted = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		while (!halted) begin
			@(posedge clk);
			#1;
		end
		if (expRegQ.size() != 0) begin
			errors++;
			$display("%0d expected write-backs missing at halt", expRegQ.size());
		end
		// A request while halted stays unanswered
		loadReq = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		loadReq = 1'b0;
	endtask

	initial begin
		#(watchCycles * clkPeriod);
		$display("Timeout: run did not finish within %0d cycles", watchCycles);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		rst = 1'b1;
		start = 1'b0;
		loadReq = 1'b0;
		loadAddr = '0;
		loadData = '0;
		coreStarted = 1'b0;
		expectErr = 1'b0;
		lfsrState = 8'd82;
		lastDest = '0;
		progLen = 0;
		errors = 0;
		wbChecks = 0;
		buildArith();
		runProgram("arithmetic");
		buildBranch();
		runProgram("branch");
		buildIllegal();
		runProgram("illegal opcode");
		$display("Write-backs checked: %0d, errors: %0d", wbChecks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/tbClock.sv ====
// ==========================================================================
// Testbench clock
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

module tbClock #(
	parameter int period = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(period / 2);
			clk = ~clk;
		end
	end

endmodule

`default_nettype wire
